//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the log holds the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_mem_top -f tb.f -o sim_mem \
    > build.log 2>&1 &&
  ./obj_dir/sim_mem > sim.log 2>&1 ;
grep -qx "Regression passed" sim.log 2>/dev/null && echo "PASS" ||
  { echo "FAIL, see build.log and sim.log"; exit 1; }

//--- tb.f
verilog/mem_pkg.sv
verilog/irq_timer.sv
verilog/stream_ack.sv
verilog/byte_ram.sv
verilog/bus_ctrl.sv
verilog/mem_top.sv
testbench/tb_mem_asserts.sv
testbench/tb_mem_top.sv

//--- testbench/tb_mem_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_asserts (
  input logic                 clk,
  input logic                 resetn,
  input logic                 ready,        // Bus completion pulse
  input mem_pkg::stream_vec_t stream_valid  // Outgoing strobes
);

  // A second ready cycle would complete the next request early
  ready_pulse: assert property (@(posedge clk) disable iff (!resetn) ready |=> !ready)
    else $error("Bus ready high for two cycles in a row");

  // Only one outgoing port decodes an address
  valid_onehot: assert property (@(posedge clk) disable iff (!resetn) $onehot0(stream_valid))
    else $error("More than one stream_valid bit set");

  reset_ready: assert property (@(posedge clk) !resetn |=> !ready)
    else $error("Bus ready set during reset");

  reset_valid: assert property (@(posedge clk) !resetn |-> stream_valid == '0)
    else $error("stream_valid set during reset");

endmodule

bind bus_ctrl tb_mem_asserts u_asserts (
  .clk          (clk),
  .resetn       (resetn),
  .ready        (mem_rsp.ready),
  .stream_valid (stream_valid)
);

`default_nettype wire

//--- testbench/tb_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_top;

  import mem_pkg::*;

  typedef struct packed {
    logic       active;  // Request outstanding
    logic       is_read;
    logic [1:0] kind;    // 0 RAM, 1 outgoing stream, 2 incoming stream
    logic [2:0] port;
    word_t      data;    // Expected read word or write data for stream_data
    int         req_cyc; // Edge count when valid was raised
  } expect_t;

  logic          clk;
  logic          resetn;
  mem_req_t      mem_req;
  mem_rsp_t      mem_rsp;
  cfg_wr_t       cfg_wr;
  stream_vec_t   stream_valid;
  word_t         stream_data;
  stream_vec_t   stream_ready;
  stream_vec_t   stream_in_valid;
  stream_words_t stream_in_data;
  stream_vec_t   stream_in_ack;
  word_t         irq;

  logic [7:0] shadow [4096];      // Byte image of the RAM
  expect_t    exp_q;
  int         seed = 32'h02efd42a;
  int         errors = 0;
  int         timeouts = 0;
  int         cyc = 0;            // Rising edges seen
  int         tcnt = 0;           // Edges since reset release
  int         fast_cnt = 0;
  int         slow_cnt = 0;
  int         vld_cnt [n_streams]; // stream_valid pulses per port
  int         ack_cnt [n_streams]; // stream_in_ack pulses per port

  mem_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Port addresses of the stream region
  function automatic word_t in_addr(input int i);
    return 32'h1000_0004 + 32'(8 * i);
  endfunction

  function automatic word_t out_addr(input int i);
    return 32'h1000_0008 + 32'(8 * i);
  endfunction

  // Expected read word from the shadow or the modeled source
  function automatic word_t ref_read(input word_t addr);
    for (int i = 0; i < n_streams; i++) begin
      if (addr == in_addr(i)) return stream_in_data[i];
    end
    return {shadow[{addr[11:2], 2'd3}], shadow[{addr[11:2], 2'd2}],
            shadow[{addr[11:2], 2'd1}], shadow[{addr[11:2], 2'd0}]};
  endfunction

  function automatic word_t exp_irq(input int t);
    word_t w;
    w = '0;
    w[4] = (t % 8192) == 8191;  // Low 13 bits all ones
    w[5] = (t % 65536) == 65535; // Whole counter all ones
    return w;
  endfunction

  task automatic flag_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timeouts++;
  endtask

  task automatic finish_run;
    $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // Compare process on the rising edge while inputs are settled
  always @(posedge clk) begin
    if (resetn) begin
      assert (irq == exp_irq(tcnt))
        else flag_error($sformatf("irq %h, expected %h", irq, exp_irq(tcnt)));
      if (irq[4]) fast_cnt++;
      if (irq[5]) slow_cnt++;
      tcnt++;
    end
    for (int i = 0; i < n_streams; i++) begin
      if (stream_valid[i]) vld_cnt[i]++;
      if (stream_in_ack[i]) ack_cnt[i]++;
    end
    if (|stream_valid) begin
      assert (stream_data == exp_q.data)
        else flag_error($sformatf("stream_data %h, expected %h", stream_data, exp_q.data));
    end
    if (mem_rsp.ready) begin
      assert (exp_q.active) else flag_error("ready with no request pending");
      if (exp_q.is_read) begin
        assert (mem_rsp.rdata == exp_q.data)
          else flag_error($sformatf("rdata %h, expected %h", mem_rsp.rdata, exp_q.data));
      end
      if (exp_q.kind == 2'd0) begin // RAM has fixed latency
        assert (cyc - exp_q.req_cyc == 1)
          else flag_error($sformatf("RAM latency %0d", cyc - exp_q.req_cyc));
      end
      if (exp_q.kind == 2'd1) begin
        assert (stream_ready[exp_q.port]) else flag_error("ready before the sink was ready");
      end
      exp_q.active = 1'b0;
    end
    cyc++;
  end

  task automatic issue(input word_t addr, input word_t wdata, input logic [3:0] wstrb,
                       input logic [1:0] kind, input int port);
    exp_q = '{active: 1'b1, is_read: (wstrb == 4'h0), kind: kind, port: 3'(port),
              data: (wstrb == 4'h0) ? ref_read(addr) : wdata, req_cyc: cyc};
    if (kind == 2'd0) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) shadow[{addr[11:2], 2'(b)}] = wdata[8*b +: 8]; // Unstrobed bytes kept
      end
    end
    mem_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
  endtask

  task automatic wait_ready(input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!mem_rsp.ready && n < 64);
    if (!mem_rsp.ready) report_timeout(what);
    mem_req = '0;    // Drop valid
    @(negedge clk);  // Idle cycle so the next valid rises
  endtask

  task automatic clear_counts;
    for (int j = 0; j < n_streams; j++) begin
      vld_cnt[j] = 0;
      ack_cnt[j] = 0;
    end
  endtask

  task automatic check_pulses(input int cnt [n_streams], input int port, input string what);
    for (int j = 0; j < n_streams; j++) begin
      assert (cnt[j] == ((j == port) ? 1 : 0))
        else flag_error($sformatf("%s port %0d pulsed %0d times", what, j, cnt[j]));
    end
  endtask

  // All bus, loader, stream and timer checks, left early on a timeout
  task automatic run_sequence;
    word_t      addr_list [16];
    word_t      addr;
    logic [7:0] data;
    int         d;

    // Full word first and then a partial overwrite
    for (int k = 0; k < 16; k++) begin
      addr_list[k] = $random(seed) & 32'h0000_0ffc;
      issue(addr_list[k], $random(seed), 4'hf, 2'd0, 0);
      wait_ready("RAM write");
      if (timeouts != 0) return;
      issue(addr_list[k], $random(seed), 4'($random(seed)), 2'd0, 0);
      wait_ready("RAM write");
      if (timeouts != 0) return;
    end
    for (int k = 0; k < 16; k++) begin
      issue(addr_list[k], 32'h0, 4'h0, 2'd0, 0);
      wait_ready("RAM read");
      if (timeouts != 0) return;
    end

    // Loader fills one word a byte at a time
    for (int k = 0; k < 3; k++) begin
      addr = $random(seed) & 32'h0000_0ffc;
      for (int b = 0; b < 4; b++) begin
        data = 8'($random(seed));
        cfg_wr = '{wr_en: 1'b1, addr: {addr[23:2], 2'(b)}, din: data};
        shadow[{addr[11:2], 2'(b)}] = data;
        @(negedge clk);
      end
      cfg_wr = '0;
      issue(addr, 32'h0, 4'h0, 2'd0, 0);
      wait_ready("read after configuration writes");
      if (timeouts != 0) return;
    end

    for (int i = 0; i < n_streams; i++) begin
      clear_counts();
      d = 1 + ($random(seed) & 7); // Sink back-pressure
      issue(out_addr(i), $random(seed), 4'hf, 2'd1, i);
      repeat (d) @(negedge clk);
      stream_ready[i] = 1'b1;
      wait_ready("outgoing stream ready");
      if (timeouts != 0) return;
      stream_ready = '0;
      check_pulses(vld_cnt, i, "stream_valid");
    end

    for (int i = 0; i < n_streams; i++) begin
      clear_counts();
      stream_in_data[i] = $random(seed);
      d = $random(seed) & 7;       // Source delay from 0 to 7 cycles
      issue(in_addr(i), 32'h0, 4'h0, 2'd2, i);
      repeat (d) @(negedge clk);
      stream_in_valid[i] = 1'b1;
      wait_ready("incoming stream ready");
      if (timeouts != 0) return;
      repeat (4) @(negedge clk);   // Acknowledge trails the read
      stream_in_valid = '0;
      @(negedge clk);
      check_pulses(ack_cnt, i, "stream_in_ack");
    end

    d = 0;
    while (slow_cnt == 0 && d < 70000) begin
      @(negedge clk);
      d++;
    end
    if (slow_cnt == 0) begin
      report_timeout("the slow timer interrupt");
    end else begin
      assert (fast_cnt == 8 && slow_cnt == 1)
        else flag_error($sformatf("timer pulses fast %0d slow %0d", fast_cnt, slow_cnt));
    end
  endtask

  initial begin
    resetn          = 1'b0;
    mem_req         = '0;
    cfg_wr          = '0;
    stream_ready    = '0;
    stream_in_valid = '0;
    stream_in_data  = '0;
    exp_q           = '0;
    clear_counts();
    repeat (5) @(negedge clk);
    resetn = 1'b1;
    run_sequence();
    finish_run();
  end

endmodule

`default_nettype wire

//--- verilog/bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl (
  input  logic                          clk,
  input  logic                          resetn,
  input  mem_pkg::mem_req_t             mem_req,
  output mem_pkg::mem_rsp_t             mem_rsp,
  output mem_pkg::stream_vec_t          stream_valid,
  output mem_pkg::word_t                stream_data,
  input  mem_pkg::stream_vec_t          stream_ready,
  input  mem_pkg::stream_vec_t          stream_in_valid,
  input  mem_pkg::stream_words_t        stream_in_data,
  output logic [mem_pkg::n_lanes-1:0]   ram_we,
  output logic [mem_pkg::ram_addr_w-1:0] ram_addr,
  output mem_pkg::word_t                ram_wdata,
  input  mem_pkg::word_t                ram_rdata,
  output mem_pkg::stream_vec_t          rd_hit
);

  import mem_pkg::*;

  logic        ready_q;   // Registered ready pulse
  logic        valid_q;   // Valid one cycle ago
  logic        pending;   // Request waiting for ready
  logic        valid_rise;
  logic        ram_hit;   // Address falls in RAM region
  stream_vec_t out_hit;   // Outgoing port decode
  stream_vec_t in_hit;    // Incoming port decode
  stream_vec_t rd_sel;    // One-hot read source, zero selects RAM
  word_t       in_word;   // Selected incoming word
  word_t       rd_word;

  assign pending    = mem_req.valid && !ready_q;
  assign valid_rise = mem_req.valid && !valid_q; // First cycle of a request
  assign ram_hit    = (mem_req.addr < stream_base);

  // Exact compare against the address map
  always_comb begin
    out_hit = '0;
    in_hit  = '0;
    for (int i = 0; i < n_streams; i++) begin
      out_hit[i] = (mem_req.addr == stream_out_addr[i]);
      in_hit[i]  = (mem_req.addr == stream_in_addr[i]);
    end
  end

  assign stream_valid = out_hit & {n_streams{valid_rise}}; // Single pulse per request
  assign stream_data  = mem_req.wdata;                     // Same word for every port
  assign rd_hit       = in_hit & {n_streams{mem_req.valid}};

  // Stream addresses never reach the RAM
  assign ram_we    = mem_req.wstrb & {n_lanes{pending && ram_hit}};
  assign ram_addr  = mem_req.addr[ram_addr_w+1:2];
  assign ram_wdata = mem_req.wdata;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      rd_sel  <= '0;
    end else begin
      valid_q <= mem_req.valid;
      ready_q <= 1'b0; // Ready never lasts more than a cycle
      if (pending) begin
        if (|out_hit) begin
          ready_q <= |(out_hit & stream_ready);   // Wait for the sink
        end else if (|in_hit) begin
          ready_q <= |(in_hit & stream_in_valid); // Wait for the source
        end else begin
          ready_q <= 1'b1;                        // RAM and unmapped, fixed latency
        end
        rd_sel <= in_hit; // held through the ready cycle
      end
    end
  end

  // Steer incoming word by the registered select
  always_comb begin
    in_word = '0;
    for (int i = 0; i < n_streams; i++) begin
      if (rd_sel[i]) begin
        in_word = stream_in_data[i];
      end
    end
  end

  assign rd_word = (|rd_sel) ? in_word : ram_rdata;
  assign mem_rsp = '{ready: ready_q, rdata: rd_word};

endmodule

`default_nettype wire

//--- verilog/byte_ram.sv
`timescale 1ns/1ns
`default_nettype none

module byte_ram (
  input  logic                           clk,
  input  logic [mem_pkg::n_lanes-1:0]    ram_we,    // Per-lane strobes
  input  logic [mem_pkg::ram_addr_w-1:0] ram_addr,  // Bus word address
  input  mem_pkg::word_t                 ram_wdata,
  output mem_pkg::word_t                 ram_rdata, // Registered read
  input  mem_pkg::cfg_wr_t               cfg_wr     // Byte-wide loader port
);

  import mem_pkg::*;

  localparam int depth = 2 ** ram_addr_w;

  logic [ram_addr_w-1:0] cfg_word; // Loader word address
  logic [n_lanes-1:0]    cfg_we;   // Loader lane strobes, one-hot

  assign cfg_word = cfg_wr.addr[ram_addr_w+1:2];

  always_comb begin
    cfg_we = '0;
    cfg_we[cfg_wr.addr[1:0]] = cfg_wr.wr_en; // Low bits pick the lane
  end

  for (genvar l = 0; l < n_lanes; l++) begin : g_lane
    logic [7:0] mem [depth]; // One byte lane, contents start undefined

    always_ff @(posedge clk) begin
      if (ram_we[l]) begin
        mem[ram_addr] <= ram_wdata[8*l +: 8];
      end
      if (cfg_we[l]) begin
        mem[cfg_word] <= cfg_wr.din; // Loader wins on a same-word collision
      end
      ram_rdata[8*l +: 8] <= mem[ram_addr]; // Read-first
    end
  end

endmodule

`default_nettype wire

//--- verilog/irq_timer.sv
`timescale 1ns/1ns
`default_nettype none

module irq_timer (
  input  logic           clk,
  input  logic           resetn,
  output mem_pkg::word_t irq     // Only the two timer bits are ever set
);

  import mem_pkg::*;

  logic [timer_w-1:0] cycle_cnt; // Free-running, wraps

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  always_comb begin
    irq               = '0;
    irq[irq_fast_bit] = &cycle_cnt[irq_fast_w-1:0]; // Every 8192 cycles
    irq[irq_slow_bit] = &cycle_cnt;                 // Every 65536 cycles
  end

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int word_w     = 32;  // Data word width
  localparam int n_lanes    = 4;   // Bytes per word
  localparam int ram_addr_w = 10;  // 1024 words of RAM
  localparam int n_streams  = 5;   // Ports per direction
  localparam int cnt_w      = 8;   // Ack counter width
  localparam int timer_w    = 16;  // Cycle counter width
  localparam int irq_fast_bit = 4;  // Fast timer irq line
  localparam int irq_slow_bit = 5;  // Slow timer irq line
  localparam int irq_fast_w   = 13; // Low counter bits for the fast irq

  typedef logic [word_w-1:0]    word_t;          // One bus word
  typedef logic [n_streams-1:0] stream_vec_t;    // One bit per stream port
  typedef word_t [n_streams-1:0] stream_words_t; // One word per stream port

  localparam word_t stream_base = 32'h1000_0000; // Start of stream region, RAM sits below

  // Incoming ports are read, outgoing ports are written, interleaved by 8
  localparam word_t stream_in_addr [n_streams] = '{
    stream_base + 32'h04, stream_base + 32'h0c, stream_base + 32'h14,
    stream_base + 32'h1c, stream_base + 32'h24
  };
  localparam word_t stream_out_addr [n_streams] = '{
    stream_base + 32'h08, stream_base + 32'h10, stream_base + 32'h18,
    stream_base + 32'h20, stream_base + 32'h28
  };

  typedef struct packed {
    logic               valid; // Request present
    word_t              addr;  // Byte address
    word_t              wdata; // Write data
    logic [n_lanes-1:0] wstrb; // Byte strobes, zero on a read
  } mem_req_t;

  typedef struct packed {
    logic  ready; // One-cycle completion pulse
    word_t rdata; // Read data, valid with ready
  } mem_rsp_t;

  typedef struct packed {
    logic        wr_en; // Byte write strobe
    logic [23:0] addr;  // Byte address into RAM
    logic [7:0]  din;   // Byte to write
  } cfg_wr_t;

endpackage

`default_nettype wire

//--- verilog/mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_top (
  input  logic                   clk,
  input  logic                   resetn,
  input  mem_pkg::mem_req_t      mem_req,         // From the core
  output mem_pkg::mem_rsp_t      mem_rsp,         // Back to the core
  input  mem_pkg::cfg_wr_t       cfg_wr,          // External RAM loader
  output mem_pkg::stream_vec_t   stream_valid,    // Outgoing strobes
  output mem_pkg::word_t         stream_data,     // Shared outgoing data
  input  mem_pkg::stream_vec_t   stream_ready,    // Outgoing back-pressure
  input  mem_pkg::stream_vec_t   stream_in_valid, // Incoming data present
  input  mem_pkg::stream_words_t stream_in_data,  // Incoming words
  output mem_pkg::stream_vec_t   stream_in_ack,   // Incoming consume pulses
  output mem_pkg::word_t         irq              // Timer interrupts
);

  import mem_pkg::*;

  logic [n_lanes-1:0]    ram_we;    // Qualified lane strobes
  logic [ram_addr_w-1:0] ram_addr;  // Word address
  word_t                 ram_wdata;
  word_t                 ram_rdata; // Registered RAM word
  stream_vec_t           rd_hit;    // Incoming port address match

  bus_ctrl u_bus_ctrl (
    .clk             (clk),
    .resetn          (resetn),
    .mem_req         (mem_req),
    .mem_rsp         (mem_rsp),
    .stream_valid    (stream_valid),
    .stream_data     (stream_data),
    .stream_ready    (stream_ready),
    .stream_in_valid (stream_in_valid),
    .stream_in_data  (stream_in_data),
    .ram_we          (ram_we),
    .ram_addr        (ram_addr),
    .ram_wdata       (ram_wdata),
    .ram_rdata       (ram_rdata),
    .rd_hit          (rd_hit)
  );

  byte_ram u_byte_ram (
    .clk       (clk),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .cfg_wr    (cfg_wr)
  );

  stream_ack u_stream_ack (
    .clk             (clk),
    .resetn          (resetn),
    .rd_hit          (rd_hit),
    .stream_in_valid (stream_in_valid),
    .stream_in_ack   (stream_in_ack)
  );

  irq_timer u_irq_timer (
    .clk    (clk),
    .resetn (resetn),
    .irq    (irq)
  );

endmodule

`default_nettype wire

//--- verilog/stream_ack.sv
`timescale 1ns/1ns
`default_nettype none

module stream_ack (
  input  logic                 clk,
  input  logic                 resetn,
  input  mem_pkg::stream_vec_t rd_hit,          // Address match per incoming port
  input  mem_pkg::stream_vec_t stream_in_valid, // Source has data
  output mem_pkg::stream_vec_t stream_in_ack    // One pulse per completed read
);

  import mem_pkg::*;

  stream_vec_t      hit_q;                // Previous match
  stream_vec_t      hit_rise;             // New read seen
  stream_vec_t      ack_due;              // Reads outstanding and source valid
  logic [cnt_w-1:0] rd_cnt  [n_streams];  // Reads seen
  logic [cnt_w-1:0] ack_cnt [n_streams];  // Acks sent

  assign hit_rise = rd_hit & ~hit_q;

  always_comb begin
    for (int i = 0; i < n_streams; i++) begin
      ack_due[i] = (rd_cnt[i] != ack_cnt[i]) && stream_in_valid[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      hit_q         <= '0;
      stream_in_ack <= '0;
      for (int i = 0; i < n_streams; i++) begin
        rd_cnt[i]  <= '0;
        ack_cnt[i] <= '0;
      end
    end else begin
      hit_q         <= rd_hit;
      stream_in_ack <= ack_due; // Drops again once the counts match
      for (int i = 0; i < n_streams; i++) begin
        if (hit_rise[i]) begin
          rd_cnt[i] <= rd_cnt[i] + 1'b1; // Wraps, only the difference matters
        end
        if (ack_due[i]) begin
          ack_cnt[i] <= ack_cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire
